// File: all.f
rtl/rvPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/rvCore.sv
test/retireChecker.sv
test/rvCoreTb.sv

// File: rtl/decodeStage.sv
// decodeStage instruction decode, register file, load-use detection and the ID/EX register
`timescale 1ns/1ns
`default_nettype none

module decodeStage import rvPkg::*; (
	input logic clk,
	input logic arstN,
	input ifIdT ifId,
	input logic ifIdValid,
	input logic redirect,
	input memWbT memWb,
	input logic memWbValid,
	output idExT idEx,
	output logic idExValid,
	output logic stallIf,
	output logic haltSeen
);

	logic [xlen-1:0] regs [32];
	logic [xlen-1:0] instr;
	opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	ctrlT ctrl;
	logic [xlen-1:0] imm;
	logic useRs1;
	logic useRs2;
	logic legal;
	logic wbWrite;
	logic [xlen-1:0] rs1Data;
	logic [xlen-1:0] rs2Data;
	logic loadUse;

	assign instr = ifId.instr;
	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	always_comb begin
		ctrl = ctrlNone;
		imm = '0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		legal = 1'b1;
		case (opcode)
			opReg: begin
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				ctrl.regWen = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: ctrl.aluOp = aluAdd;
					{7'b0100000, 3'b000}: ctrl.aluOp = aluSub;
					{7'b0000000, 3'b111}: ctrl.aluOp = aluAnd;
					{7'b0000000, 3'b110}: ctrl.aluOp = aluOr;
					{7'b0000000, 3'b100}: ctrl.aluOp = aluXor;
					{7'b0000000, 3'b010}: ctrl.aluOp = aluSlt;
					default: legal = 1'b0;
				endcase
			end
			opImm: begin
				// only addi
				useRs1 = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.regWen = 1'b1;
				imm = {{20{instr[31]}}, instr[31:20]};
				legal = (funct3 == 3'b000);
			end
			opLoad: begin
				useRs1 = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.regWen = 1'b1;
				ctrl.memRen = 1'b1;
				imm = {{20{instr[31]}}, instr[31:20]};
				legal = (funct3 == 3'b010);
			end
			opStore: begin
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.memWen = 1'b1;
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				legal = (funct3 == 3'b010);
			end
			opBranch: begin
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				ctrl.isBranch = 1'b1;
				ctrl.aluOp = (funct3 == 3'b001) ? aluNe : aluEq;
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
				legal = (funct3 == 3'b000) || (funct3 == 3'b001);
			end
			opJal: begin
				ctrl.isJal = 1'b1;
				ctrl.regWen = 1'b1;
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			opSystem: begin
				ctrl.isHalt = 1'b1;
				legal = (instr == ebreakInstr);
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			// retires as a no-op
			ctrl = ctrlNone;
			ctrl.illegal = 1'b1;
			useRs1 = 1'b0;
			useRs2 = 1'b0;
		end
		if (rd == 5'd0) begin
			ctrl.regWen = 1'b0;
		end
	end

	// writeback port, x0 is never written
	assign wbWrite = memWbValid && memWb.regWen && (memWb.rd != 5'd0);

	always_ff @(posedge clk) begin
		if (wbWrite) begin
			regs[memWb.rd] <= memWb.wbData;
		end
	end

	// same-cycle writes are visible to the read
	assign rs1Data = (rs1 == 5'd0) ? '0 :
		((wbWrite && memWb.rd == rs1) ? memWb.wbData : regs[rs1]);
	assign rs2Data = (rs2 == 5'd0) ? '0 :
		((wbWrite && memWb.rd == rs2) ? memWb.wbData : regs[rs2]);

	// load in EX whose rd feeds the instruction in ID
	assign loadUse = ifIdValid && idExValid && idEx.ctrl.memRen && (idEx.rd != 5'd0) &&
		((useRs1 && rs1 == idEx.rd) || (useRs2 && rs2 == idEx.rd));
	assign stallIf = loadUse;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idExValid <= 1'b0;
			idEx <= idExBubble;
			haltSeen <= 1'b0;
		end else begin
			if (ifIdValid && ctrl.isHalt && !redirect && !loadUse) begin
				haltSeen <= 1'b1;
			end
			if (!ifIdValid || redirect || haltSeen || loadUse) begin
				idExValid <= 1'b0;
				idEx <= idExBubble;
			end else begin
				idExValid <= 1'b1;
				idEx <= '{pc: ifId.pc, ctrl: ctrl, rs1: rs1, rs2: rs2, rd: rd,
					rs1Data: rs1Data, rs2Data: rs2Data, imm: imm};
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
// executeStage operand forwarding, ALU, branch and jump resolution and the EX/MEM register
`timescale 1ns/1ns
`default_nettype none

module executeStage import rvPkg::*; (
	input logic clk,
	input logic arstN,
	input idExT idEx,
	input logic idExValid,
	input memWbT memWb,
	input logic memWbValid,
	output exMemT exMem,
	output logic exMemValid,
	output logic redirect,
	output logic [xlen-1:0] redirectPc
);

	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] rs2Fwd;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] linkPc;
	logic taken;

	// nearest producer wins; loads in EX/MEM are covered by the stall
	function automatic logic [xlen-1:0] forwardOperand(
		input logic [4:0] rs,
		input logic [xlen-1:0] captured,
		input exMemT exReg,
		input logic exValid,
		input memWbT wbReg,
		input logic wbValid
	);
		if (rs != 5'd0 && exValid && exReg.ctrl.regWen && !exReg.ctrl.memRen &&
				exReg.rd == rs) begin
			return exReg.aluResult;
		end else if (rs != 5'd0 && wbValid && wbReg.regWen && wbReg.rd == rs) begin
			return wbReg.wbData;
		end
		return captured;
	endfunction

	assign opA = forwardOperand(idEx.rs1, idEx.rs1Data, exMem, exMemValid, memWb, memWbValid);
	assign rs2Fwd = forwardOperand(idEx.rs2, idEx.rs2Data, exMem, exMemValid, memWb,
		memWbValid);
	assign opB = idEx.ctrl.useImm ? idEx.imm : rs2Fwd;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluXor: aluResult = opA ^ opB;
			aluSlt: aluResult = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
			aluEq: aluResult = {{(xlen-1){1'b0}}, opA == opB};
			aluNe: aluResult = {{(xlen-1){1'b0}}, opA != opB};
			default: aluResult = '0;
		endcase
	end

	// branch condition comes out of the ALU as bit 0
	assign taken = idEx.ctrl.isBranch && aluResult[0];
	assign redirect = idExValid && (taken || idEx.ctrl.isJal);
	assign redirectPc = idEx.pc + idEx.imm;
	assign linkPc = idEx.pc + 32'd4;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exMemValid <= 1'b0;
			exMem <= exMemBubble;
		end else begin
			exMemValid <= idExValid;
			if (idExValid) begin
				// jal carries its link value as the result
				exMem <= '{pc: idEx.pc, ctrl: idEx.ctrl, rd: idEx.rd,
					aluResult: idEx.ctrl.isJal ? linkPc : aluResult, storeData: rs2Fwd};
			end else begin
				exMem <= exMemBubble;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetchStage.sv
// fetchStage program counter, loadable instruction memory and the IF/ID register
`timescale 1ns/1ns
`default_nettype none

module fetchStage import rvPkg::*; #(
	parameter int imemDepth = 256
) (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic progWe,
	input logic stallIf,
	input logic redirect,
	input logic haltSeen,
	input logic [$clog2(imemDepth)-1:0] progAddr,
	input logic [xlen-1:0] progData,
	input logic [xlen-1:0] redirectPc,
	output ifIdT ifId,
	output logic ifIdValid
);

	localparam int iAddrW = $clog2(imemDepth);

	logic [xlen-1:0] imem [imemDepth];
	logic [xlen-1:0] pc;
	logic [xlen-1:0] fetchWord;
	logic running;

	// program load port, one word per cycle
	always_ff @(posedge clk) begin
		if (progWe) begin
			imem[progAddr] <= progData;
		end
	end

	// word addressed, low pc bits ignored
	assign fetchWord = imem[pc[iAddrW+1:2]];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			pc <= '0;
			ifIdValid <= 1'b0;
			ifId <= ifIdBubble;
		end else begin
			if (start) begin
				running <= 1'b1;
			end
			if (redirect) begin
				// the slot fetched this cycle is on the wrong path
				pc <= redirectPc;
				ifIdValid <= 1'b0;
				ifId <= ifIdBubble;
			end else if (running && !haltSeen) begin
				if (!stallIf) begin
					ifId <= '{pc: pc, instr: fetchWord};
					ifIdValid <= 1'b1;
					pc <= pc + 32'd4;
				end
			end else begin
				// idle before start, frozen after a halt
				ifIdValid <= 1'b0;
				ifId <= ifIdBubble;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/memoryStage.sv
// memoryStage word data memory, writeback value select and the MEM/WB register
`timescale 1ns/1ns
`default_nettype none

module memoryStage import rvPkg::*; #(
	parameter int dmemDepth = 256
) (
	input logic clk,
	input logic arstN,
	input exMemT exMem,
	input logic exMemValid,
	output memWbT memWb,
	output logic memWbValid
);

	localparam int dAddrW = $clog2(dmemDepth);

	logic [xlen-1:0] dmem [dmemDepth];
	logic [dAddrW-1:0] dAddr;
	logic [xlen-1:0] loadData;
	logic [xlen-1:0] wbData;
	logic regWen;
	logic storeEn;

	assign dAddr = exMem.aluResult[dAddrW+1:2];
	assign storeEn = exMemValid && exMem.ctrl.memWen && !exMem.ctrl.illegal;

	always_ff @(posedge clk) begin
		if (storeEn) begin
			dmem[dAddr] <= exMem.storeData;
		end
	end

	// combinational read, a store one cycle earlier is already visible
	assign loadData = dmem[dAddr];

	assign regWen = exMem.ctrl.regWen && !exMem.ctrl.illegal;
	// nothing written means a zero in the trace
	assign wbData = !regWen ? '0 : (exMem.ctrl.memRen ? loadData : exMem.aluResult);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memWbValid <= 1'b0;
			memWb <= memWbBubble;
		end else begin
			memWbValid <= exMemValid;
			if (exMemValid) begin
				memWb <= '{pc: exMem.pc, regWen: regWen, rd: exMem.rd, wbData: wbData,
					isHalt: exMem.ctrl.isHalt};
			end else begin
				memWb <= memWbBubble;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/rvCore.sv
// rvCore five-stage RV32I subset pipeline with program load port, retire trace and halt
`timescale 1ns/1ns
`default_nettype none

module rvCore import rvPkg::*; #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256
) (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic progWe,
	input logic [$clog2(imemDepth)-1:0] progAddr,
	input logic [xlen-1:0] progData,
	output retireT retire,
	output logic retireValid,
	output logic halted
);

	ifIdT ifId;
	logic ifIdValid;
	idExT idEx;
	logic idExValid;
	exMemT exMem;
	logic exMemValid;
	memWbT memWb;
	logic memWbValid;
	logic stallIf;
	logic haltSeen;
	logic redirect;
	logic [xlen-1:0] redirectPc;

	fetchStage #(.imemDepth(imemDepth)) fetchStage_inst (
		.clk(clk), .arstN(arstN), .start(start), .progWe(progWe), .stallIf(stallIf),
		.redirect(redirect), .haltSeen(haltSeen), .progAddr(progAddr), .progData(progData),
		.redirectPc(redirectPc), .ifId(ifId), .ifIdValid(ifIdValid)
	);

	decodeStage decodeStage_inst (
		.clk(clk), .arstN(arstN), .ifId(ifId), .ifIdValid(ifIdValid), .redirect(redirect),
		.memWb(memWb), .memWbValid(memWbValid), .idEx(idEx), .idExValid(idExValid),
		.stallIf(stallIf), .haltSeen(haltSeen)
	);

	executeStage executeStage_inst (
		.clk(clk), .arstN(arstN), .idEx(idEx), .idExValid(idExValid), .memWb(memWb),
		.memWbValid(memWbValid), .exMem(exMem), .exMemValid(exMemValid),
		.redirect(redirect), .redirectPc(redirectPc)
	);

	memoryStage #(.dmemDepth(dmemDepth)) memoryStage_inst (
		.clk(clk), .arstN(arstN), .exMem(exMem), .exMemValid(exMemValid), .memWb(memWb),
		.memWbValid(memWbValid)
	);

	// trace taken straight from the writeback slot
	assign retire = '{pc: memWb.pc, rd: memWb.rd, wbData: memWb.wbData, regWen: memWb.regWen};
	assign retireValid = memWbValid;

	// sticky until reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			halted <= 1'b0;
		end else if (memWbValid && memWb.isHalt) begin
			halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rvPkg.sv
// rvPkg shared ISA encodings, control fields and pipeline records of the core
`default_nettype none

package rvPkg;

	localparam int xlen = 32;

	// addi x0, x0, 0 and the one system encoding we accept
	localparam logic [xlen-1:0] nopInstr = 32'h0000_0013;
	localparam logic [xlen-1:0] ebreakInstr = 32'h0010_0073;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opReg = 7'b0110011,
		opImm = 7'b0010011,
		opLoad = 7'b0000011,
		opStore = 7'b0100011,
		opBranch = 7'b1100011,
		opJal = 7'b1101111,
		opSystem = 7'b1110011
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluEq,
		aluNe
	} aluOpT;

	// regWen is never set for rd == x0
	typedef struct packed {
		aluOpT aluOp;
		logic useImm;
		logic regWen;
		logic memRen;
		logic memWen;
		logic isBranch;
		logic isJal;
		logic isHalt;
		logic illegal;
	} ctrlT;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
	} ifIdT;

	typedef struct packed {
		logic [xlen-1:0] pc;
		ctrlT ctrl;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [xlen-1:0] rs1Data;
		logic [xlen-1:0] rs2Data;
		logic [xlen-1:0] imm;
	} idExT;

	typedef struct packed {
		logic [xlen-1:0] pc;
		ctrlT ctrl;
		logic [4:0] rd;
		logic [xlen-1:0] aluResult;
		logic [xlen-1:0] storeData;
	} exMemT;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic regWen;
		logic [4:0] rd;
		logic [xlen-1:0] wbData;
		logic isHalt;
	} memWbT;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [4:0] rd;
		logic [xlen-1:0] wbData;
		logic regWen;
	} retireT;

	// empty slot contents, all enables low
	localparam ctrlT ctrlNone = '{aluOp: aluAdd, useImm: 1'b0, regWen: 1'b0, memRen: 1'b0,
		memWen: 1'b0, isBranch: 1'b0, isJal: 1'b0, isHalt: 1'b0, illegal: 1'b0};
	localparam ifIdT ifIdBubble = '{pc: '0, instr: nopInstr};
	localparam idExT idExBubble = '{pc: '0, ctrl: ctrlNone, rs1: '0, rs2: '0, rd: '0,
		rs1Data: '0, rs2Data: '0, imm: '0};
	localparam exMemT exMemBubble = '{pc: '0, ctrl: ctrlNone, rd: '0, aluResult: '0,
		storeData: '0};
	localparam memWbT memWbBubble = '{pc: '0, regWen: 1'b0, rd: '0, wbData: '0, isHalt: 1'b0};

endpackage

`default_nettype wire

// File: test/retireChecker.sv
// retireChecker compares the core retire trace and halt with the expected records
`timescale 1ns/1ns
`default_nettype none

module retireChecker import rvPkg::*; (
	input logic clk,
	input logic arstN,
	input retireT retire,
	input logic retireValid,
	input logic halted
);

	retireT expQ[$];
	int testId = 0;
	int testErrors = 0;
	int errorTotal = 0;
	int checkedTotal = 0;
	logic prevValid = 1'b0;
	logic prevHalted = 1'b0;

	task automatic beginTest(input int id);
		expQ.delete();
		testId = id;
		testErrors = 0;
	endtask

	task automatic expectRetire(input logic [xlen-1:0] pc, input logic [4:0] rd,
			input logic [xlen-1:0] wbData, input logic regWen);
		retireT rec;
		rec.pc = pc;
		rec.rd = rd;
		rec.wbData = wbData;
		rec.regWen = regWen;
		expQ.push_back(rec);
	endtask

	task automatic noteError();
		testErrors++;
		errorTotal++;
	endtask

	task automatic compareField(input string name, input logic [xlen-1:0] expected,
			input logic [xlen-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, expected,
				actual);
			noteError();
		end
	endtask

	task automatic endTest(output int errs);
		if (expQ.size() != 0) begin
			$display("test %0d: %0d expected retirements never appeared, first missing pc %h",
				testId, expQ.size(), expQ[0].pc);
			noteError();
		end
		errs = testErrors;
	endtask

	// mid-cycle sampling, trace outputs are registered
	always @(negedge clk) begin : sample
		retireT expRec;
		if (!arstN) begin
			prevValid = 1'b0;
			prevHalted = 1'b0;
		end else begin
			// halt follows the ebreak retirement by one cycle
			if (halted && !prevHalted && !prevValid) begin
				$display("test %0d: halted rose at %0t with no retirement the cycle before",
					testId, $time);
				noteError();
			end
			if (retireValid && halted) begin
				$display("test %0d: retirement at pc %h after the core halted", testId,
					retire.pc);
				noteError();
			end else if (retireValid && expQ.size() == 0) begin
				$display("test %0d: unexpected extra retirement at pc %h", testId, retire.pc);
				noteError();
			end else if (retireValid) begin
				expRec = expQ.pop_front();
				checkedTotal++;
				compareField("retire.pc", expRec.pc, retire.pc);
				compareField("retire.regWen", expRec.regWen, retire.regWen);
				// nothing written shows up as zero
				compareField("retire.wbData", expRec.wbData, retire.wbData);
				if (expRec.regWen) begin
					compareField("retire.rd", expRec.rd, retire.rd);
				end
			end
			prevValid = retireValid;
			prevHalted = halted;
		end
	end

endmodule

`default_nettype wire

// File: test/rvCorePatterns.txt
// section: program word count, program words, retire count, records, end marker eeeeeeee
// record columns: pc rd wbData regWen, two records per line; a zero count ends the file
// test 1 register and immediate alu ops, x0 writes
0000000c
00500093 ffd00113 002081b3 40208233 0020f2b3 0020e333 0020c3b3 00112433
0020a4b3 00708013 00000533 00100073
0000000c
00000000 01 00000005 1  00000004 02 fffffffd 1
00000008 03 00000002 1  0000000c 04 00000008 1
00000010 05 00000005 1  00000014 06 fffffffd 1
00000018 07 fffffff8 1  0000001c 08 00000001 1
00000020 09 00000000 1  00000024 00 00000000 0
00000028 0a 00000000 1  0000002c 00 00000000 0
eeeeeeee
// test 2 back-to-back dependencies through ex/mem and mem/wb
00000008
00a00093 00108113 001101b3 40118233 003202b3 00128293 00528333 00100073
00000008
00000000 01 0000000a 1  00000004 02 0000000b 1
00000008 03 00000015 1  0000000c 04 0000000b 1
00000010 05 00000020 1  00000014 05 00000021 1
00000018 06 00000042 1  0000001c 00 00000000 0
eeeeeeee
// test 3 store then load, load-use stalls
0000000c
04000093 12300113 0020a023 0000a183 00318233 0040a223 0040a283 00128313
0000a383 0070a423 0080a403 00100073
0000000c
00000000 01 00000040 1  00000004 02 00000123 1
00000008 00 00000000 0  0000000c 03 00000123 1
00000010 04 00000246 1  00000014 00 00000000 0
00000018 05 00000246 1  0000001c 06 00000247 1
00000020 07 00000123 1  00000024 00 00000000 0
00000028 08 00000123 1  0000002c 00 00000000 0
eeeeeeee
// test 4 taken and not-taken branches, jal link and squash
00000011
00100093 00100113 00208663 01100193 02200193 00209463 03300193 00309663
04400213 05500213 00c002ef 06600313 07700313 001283b3 0080006f 00100413
00100073
0000000a
00000000 01 00000001 1  00000004 02 00000001 1
00000008 00 00000000 0  00000014 00 00000000 0
00000018 03 00000033 1  0000001c 00 00000000 0
00000028 05 0000002c 1  00000034 07 0000002d 1
00000038 00 00000000 0  00000040 00 00000000 0
eeeeeeee
// test 5 illegal encodings and halt with younger instructions behind it
00000008
00700093 00300113 00109133 00000073 001101b3 00100073 00100213 00100293
00000006
00000000 01 00000007 1  00000004 02 00000003 1
00000008 00 00000000 0  0000000c 00 00000000 0
00000010 03 0000000a 1  00000014 00 00000000 0
eeeeeeee
00000000

// File: test/rvCoreTb.sv
// rvCoreTb testbench that runs each pattern file section through the core
`timescale 1ns/1ns
`default_nettype none

module rvCoreTb import rvPkg::*; ();

	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;
	localparam int iAddrW = $clog2(imemDepth);
	localparam int patDepth = 1024;
	localparam int clkPeriod = 8;
	localparam int resetCycles = 16;
	localparam int drainCycles = 8;
	localparam int cyclesPerRetire = 40;
	localparam int slackCycles = 100;
	localparam logic [31:0] endMarker = 32'hEEEE_EEEE;

	logic clk;
	logic arstN;
	logic start;
	logic progWe;
	logic [iAddrW-1:0] progAddr;
	logic [xlen-1:0] progData;
	retireT retire;
	logic retireValid;
	logic halted;

	logic [31:0] pats [patDepth];
	int watchdogCycles;
	logic watchdogArmed;

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	rvCore #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) rvCore_inst (
		.clk(clk), .arstN(arstN), .start(start), .progWe(progWe), .progAddr(progAddr),
		.progData(progData), .retire(retire), .retireValid(retireValid), .halted(halted)
	);

	retireChecker retireChecker_inst (
		.clk(clk), .arstN(arstN), .retire(retire), .retireValid(retireValid),
		.halted(halted)
	);

	// cycles allowed for the whole file
	function automatic int runBudget();
		int pos;
		int total;
		int progCount;
		int retCount;
		pos = 0;
		total = slackCycles;
		while (pos < patDepth && pats[pos] != 32'd0) begin
			progCount = pats[pos];
			retCount = pats[pos + 1 + progCount];
			total += resetCycles + progCount + drainCycles + cyclesPerRetire * retCount;
			pos += progCount + 4 * retCount + 3;
		end
		return total;
	endfunction

	task automatic resetCore();
		@(negedge clk);
		arstN = 1'b0;
		start = 1'b0;
		repeat (resetCycles) @(negedge clk);
		arstN = 1'b1;
	endtask

	// one instruction word per cycle through the load port
	task automatic loadProgram(input int base, input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			progWe = 1'b1;
			progAddr = iAddrW'(i);
			progData = pats[base + i];
		end
		@(negedge clk);
		progWe = 1'b0;
	endtask

	task automatic runToHalt();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (!halted) begin
			@(negedge clk);
		end
		// extra cycles so a stray retirement still gets seen
		repeat (drainCycles) @(negedge clk);
	endtask

	initial begin : watchdog
		wait (watchdogArmed);
		repeat (watchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the core never halted", watchdogCycles);
		$display("Test failed");
		$finish;
	end

	initial begin : mainSeq
		int pos;
		int progCount;
		int retCount;
		int testErrors;
		int testCount;
		int failedTests;
		logic formatError;
		arstN = 1'b0;
		start = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		watchdogArmed = 1'b0;
		watchdogCycles = 0;
		pos = 0;
		testCount = 0;
		failedTests = 0;
		formatError = 1'b0;
		$readmemh("test/rvCorePatterns.txt", pats);
		watchdogCycles = runBudget();
		watchdogArmed = 1'b1;
		while (!formatError && pos < patDepth && pats[pos] != 32'd0) begin
			progCount = pats[pos];
			resetCore();
			loadProgram(pos + 1, progCount);
			pos += progCount + 1;
			retCount = pats[pos];
			pos++;
			retireChecker_inst.beginTest(testCount + 1);
			for (int i = 0; i < retCount; i++) begin
				retireChecker_inst.expectRetire(pats[pos], pats[pos + 1][4:0], pats[pos + 2],
					pats[pos + 3][0]);
				pos += 4;
			end
			if (pats[pos] !== endMarker) begin
				$display("pattern file section %0d has no end marker at word %0d",
					testCount + 1, pos);
				formatError = 1'b1;
			end else begin
				pos++;
				runToHalt();
				retireChecker_inst.endTest(testErrors);
				testCount++;
				if (testErrors != 0) begin
					failedTests++;
				end
				$display("test %0d: %0d retirements expected, %0d errors", testCount, retCount,
					testErrors);
			end
		end
		$display("%0d tests run, %0d with errors, %0d retirements compared, %0d errors total",
			testCount, failedTests, retireChecker_inst.checkedTotal,
			retireChecker_inst.errorTotal);
		if (testCount > 0 && failedTests == 0 && !formatError &&
				retireChecker_inst.errorTotal == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
